//--- rtl/asic_pkg.sv
package asic_pkg;

    // Bus and register file sizes
    localparam int data_w           = 8;
    localparam int addr_w           = 16;
    localparam int colour_w         = 5;
    localparam int crtc_reg_count   = 32;
    localparam int crtc_std_count   = 16;   // Writable without unlock
    localparam int acid_seq_len     = 16;
    localparam int pen_count        = 17;   // 16 pens plus border
    localparam int sprite_pal_count = 32;

    // I/O port high and low bytes
    localparam logic [7:0] port_ga        = 8'h7F;
    localparam logic [7:0] port_rom_sel   = 8'hDF;
    localparam logic [7:0] port_crtc_sel  = 8'hBC;
    localparam logic [7:0] port_crtc_data = 8'hBD;
    localparam logic [7:0] ga_mrer        = 8'h89;
    localparam logic [7:0] ga_ram_cfg     = 8'hC0;
    localparam logic [7:0] ga_pen_read    = 8'h10;

    // ASIC page offsets relative to 4000
    localparam logic [1:0]  asic_bank = 2'd1;
    localparam logic [13:0] pal_base  = 14'h2400;  // 6400-643F
    localparam logic [13:0] pal_size  = 14'h0040;
    localparam logic [13:0] pri_addr  = 14'h2800;
    localparam logic [13:0] splt_addr = 14'h2801;
    localparam logic [13:0] sscr_addr = 14'h2804;
    localparam logic [13:0] wo_last   = 14'h2807;  // End of write-only block
    localparam logic [13:0] dma_base  = 14'h2C00;
    localparam logic [13:0] dma_size  = 14'h0010;
    localparam logic [13:0] dcsr_addr = 14'h2C0F;

    // Bytes written to BC00 to unlock CRTC registers 16-31
    localparam logic [0:acid_seq_len-1][7:0] acid_seq = {
        8'hAA, 8'h00, 8'hFF, 8'h77, 8'hB3, 8'h51, 8'hA8, 8'hD4,
        8'h62, 8'h39, 8'h9C, 8'h46, 8'h2B, 8'h15, 8'h8A, 8'hCD
    };

    // One CPU address, seen as an I/O port or as a memory access
    typedef union packed {
        struct packed {
            logic [data_w-1:0] port_hi;
            logic [data_w-1:0] port_lo;
        } io;
        struct packed {
            logic [1:0]        bank;
            logic [addr_w-3:0] offset;
        } mem;
    } cpu_addr_t;

    // Hardware colour number to {red, green, blue} nibbles
    function automatic logic [11:0] hw_colour_rgb(input logic [colour_w-1:0] hw);
        logic [11:0] rgb;
        case (hw)
            5'd0:    rgb = 12'h666;  // White
            5'd1:    rgb = 12'h666;
            5'd2:    rgb = 12'h0F6;  // Sea green
            5'd3:    rgb = 12'hFF6;
            5'd4:    rgb = 12'h006;  // Blue
            5'd5:    rgb = 12'hF06;
            5'd6:    rgb = 12'h066;
            5'd7:    rgb = 12'hF66;  // Pink
            5'd8:    rgb = 12'hF06;
            5'd9:    rgb = 12'hFF6;
            5'd10:   rgb = 12'hFF0;
            5'd11:   rgb = 12'hFFF;  // Bright white
            5'd12:   rgb = 12'hF00;
            5'd13:   rgb = 12'hF0F;
            5'd14:   rgb = 12'hF60;  // Orange
            5'd15:   rgb = 12'hF6F;
            5'd16:   rgb = 12'h006;
            5'd17:   rgb = 12'h0F6;
            5'd18:   rgb = 12'h0F0;  // Bright green
            5'd19:   rgb = 12'h0FF;
            5'd20:   rgb = 12'h000;  // Black
            5'd21:   rgb = 12'h00F;
            5'd22:   rgb = 12'h060;
            5'd23:   rgb = 12'h06F;
            5'd24:   rgb = 12'h606;  // Magenta
            5'd25:   rgb = 12'h6F6;
            5'd26:   rgb = 12'h6F0;
            5'd27:   rgb = 12'h6FF;
            5'd28:   rgb = 12'h600;  // Red
            5'd29:   rgb = 12'h60F;
            5'd30:   rgb = 12'h660;
            default: rgb = 12'h66F;  // Pastel blue
        endcase
        return rgb;
    endfunction

endpackage

//--- rtl/acid_unlock.sv
module acid_unlock (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  logic                          sel_wr,    // CRTC select write this cycle
    input  logic [asic_pkg::data_w-1:0]   sel_data,
    output logic                          unlocked
);

    localparam int pos_w = $clog2(asic_pkg::acid_seq_len);

    logic [pos_w-1:0]              pos;
    logic [asic_pkg::data_w-1:0]   prev_sel;   // Last value written to the select port
    logic                          seq_match;
    logic                          last_byte;

    assign seq_match = (sel_data == asic_pkg::acid_seq[pos]);
    assign last_byte = (pos == pos_w'(asic_pkg::acid_seq_len - 1));

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pos      <= '0;
            prev_sel <= '0;
            unlocked <= 1'b0;
        end else if (sel_wr) begin
            prev_sel <= sel_data;
            // Repeated bytes neither advance nor break the sequence
            if (!unlocked && sel_data != prev_sel) begin
                if (seq_match) begin
                    pos <= pos + 1'b1;
                    if (last_byte) begin
                        unlocked <= 1'b1;  // Sticky until reset
                    end
                end else begin
                    pos <= '0;
                end
            end
        end
    end

endmodule

//--- rtl/io_port_regs.sv
module io_port_regs (
    input  logic                            clk_sys,
    input  logic                            reset,
    input  asic_pkg::cpu_addr_t             cpu_addr,
    input  logic [asic_pkg::data_w-1:0]     cpu_data_in,
    input  logic                            cpu_wr,
    input  logic                            cpu_rd,
    output logic                            io_rd_hit,
    output logic [asic_pkg::data_w-1:0]     io_rd_data,
    output logic [asic_pkg::data_w-1:0]     ram_config,
    output logic [asic_pkg::data_w-1:0]     rom_config,
    output logic [asic_pkg::data_w-1:0]     rom_select,
    output logic [asic_pkg::colour_w-1:0]   current_pen,
    output logic [asic_pkg::colour_w-1:0]   pen_ink,
    output logic [asic_pkg::data_w-1:0]     crtc_reg_select,
    output logic [asic_pkg::data_w-1:0]     crtc_regs [asic_pkg::crtc_reg_count],
    output logic                            acid_unlocked
);

    logic [asic_pkg::colour_w-1:0] ink [asic_pkg::pen_count];

    logic ga_port;
    logic pen_port;
    logic ram_port;
    logic crtc_sel_wr;
    logic crtc_data_wr;
    logic rom_sel_wr;
    logic crtc_wr_ok;

    assign ga_port  = (cpu_addr.io.port_hi == asic_pkg::port_ga);
    assign pen_port = ga_port && (cpu_addr.io.port_lo <= asic_pkg::ga_pen_read);  // 7F00-7F10
    assign ram_port = ga_port && (cpu_addr.io.port_lo[7:3] == asic_pkg::ga_ram_cfg[7:3]);

    assign crtc_sel_wr  = cpu_wr && cpu_addr.io.port_hi == asic_pkg::port_crtc_sel
                          && cpu_addr.io.port_lo == 8'h00;
    assign crtc_data_wr = cpu_wr && cpu_addr.io.port_hi == asic_pkg::port_crtc_data
                          && cpu_addr.io.port_lo == 8'h00;
    assign rom_sel_wr   = cpu_wr && cpu_addr.io.port_hi == asic_pkg::port_rom_sel
                          && cpu_addr.io.port_lo == 8'h00;

    // Upper CRTC registers only after the unlock sequence
    assign crtc_wr_ok = (crtc_reg_select < asic_pkg::crtc_std_count)
                        || (acid_unlocked && crtc_reg_select < asic_pkg::crtc_reg_count);

    assign pen_ink = (current_pen < asic_pkg::pen_count) ? ink[current_pen] : '0;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ram_config      <= '0;
            rom_config      <= '0;
            rom_select      <= '0;
            current_pen     <= '0;
            crtc_reg_select <= '0;
            for (int i = 0; i < asic_pkg::pen_count; i++) begin
                ink[i] <= '0;
            end
            for (int i = 0; i < asic_pkg::crtc_reg_count; i++) begin
                crtc_regs[i] <= '0;
            end
        end else begin
            if (cpu_wr && pen_port) begin
                if (cpu_data_in[7:6] == 2'b00) begin
                    current_pen <= cpu_data_in[asic_pkg::colour_w-1:0];
                end else if (current_pen < asic_pkg::pen_count) begin
                    ink[current_pen] <= cpu_data_in[asic_pkg::colour_w-1:0];
                end
            end
            if (cpu_wr && ga_port && cpu_addr.io.port_lo == asic_pkg::ga_mrer) begin
                rom_config <= cpu_data_in;  // MRER
            end
            if (cpu_wr && ram_port) begin
                ram_config <= cpu_addr.io.port_lo;  // Config comes from the port address
            end
            if (rom_sel_wr) begin
                rom_select <= cpu_data_in;
            end
            if (crtc_sel_wr) begin
                crtc_reg_select <= cpu_data_in;
            end
            if (crtc_data_wr && crtc_wr_ok) begin
                crtc_regs[crtc_reg_select[4:0]] <= cpu_data_in;
            end
        end
    end

    // Read-back ports
    always_comb begin
        io_rd_hit  = 1'b0;
        io_rd_data = '1;
        if (cpu_rd && ga_port) begin
            case (cpu_addr.io.port_lo)
                asic_pkg::ga_pen_read: begin
                    io_rd_hit  = 1'b1;
                    io_rd_data = {{(asic_pkg::data_w - asic_pkg::colour_w){1'b0}}, pen_ink};
                end
                asic_pkg::ga_mrer: begin
                    io_rd_hit  = 1'b1;
                    io_rd_data = rom_config;
                end
                asic_pkg::ga_ram_cfg: begin
                    io_rd_hit  = 1'b1;
                    io_rd_data = ram_config;
                end
                default: ;
            endcase
        end
    end

    acid_unlock u_acid (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .sel_wr   (crtc_sel_wr),
        .sel_data (cpu_data_in),
        .unlocked (acid_unlocked)
    );

endmodule

//--- rtl/plus_asic_page.sv
module plus_asic_page (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  asic_pkg::cpu_addr_t           cpu_addr,
    input  logic [asic_pkg::data_w-1:0]   cpu_data_in,
    input  logic                          cpu_wr,
    input  logic                          cpu_rd,
    output logic                          page_rd_hit,
    output logic [asic_pkg::data_w-1:0]   page_rd_data,
    output logic [asic_pkg::data_w-1:0]   raster_int_line,
    output logic [asic_pkg::data_w-1:0]   split_line,
    output logic [asic_pkg::data_w-1:0]   soft_scroll,
    output logic [asic_pkg::data_w-1:0]   dcsr
);

    localparam int idx_w = $clog2(asic_pkg::sprite_pal_count);

    // Each entry is {red, green, blue}
    logic [11:0] sprite_pal [asic_pkg::sprite_pal_count];

    logic [13:0]      offset;
    logic [13:0]      pal_off;
    logic [idx_w-1:0] pal_idx;
    logic             in_bank;
    logic             pal_hit;
    logic             wo_hit;
    logic             dma_hit;

    assign offset  = cpu_addr.mem.offset;
    assign in_bank = (cpu_addr.mem.bank == asic_pkg::asic_bank);
    assign pal_off = offset - asic_pkg::pal_base;
    assign pal_idx = pal_off[idx_w:1];  // Two bytes per entry

    assign pal_hit = in_bank && offset >= asic_pkg::pal_base
                     && offset < asic_pkg::pal_base + asic_pkg::pal_size;
    assign wo_hit  = in_bank && offset >= asic_pkg::pri_addr && offset <= asic_pkg::wo_last;
    assign dma_hit = in_bank && offset >= asic_pkg::dma_base
                     && offset < asic_pkg::dma_base + asic_pkg::dma_size;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            raster_int_line <= '0;
            split_line      <= '0;
            soft_scroll     <= '0;
            dcsr            <= '0;
            for (int i = 0; i < asic_pkg::sprite_pal_count; i++) begin
                sprite_pal[i] <= '0;
            end
        end else if (cpu_wr && in_bank) begin
            if (pal_hit && !pal_off[0]) begin
                sprite_pal[pal_idx] <= asic_pkg::hw_colour_rgb(
                                           cpu_data_in[asic_pkg::colour_w-1:0]);
            end
            if (pal_hit && pal_off[0]) begin
                sprite_pal[pal_idx][7:4] <= cpu_data_in[3:0];  // Green only
            end
            if (offset == asic_pkg::pri_addr)  raster_int_line <= cpu_data_in;
            if (offset == asic_pkg::splt_addr) split_line      <= cpu_data_in;
            if (offset == asic_pkg::sscr_addr) soft_scroll     <= cpu_data_in;
            if (offset == asic_pkg::dcsr_addr) dcsr            <= cpu_data_in;
        end
    end

    always_comb begin
        page_rd_hit  = cpu_rd && (pal_hit || wo_hit || dma_hit);
        page_rd_data = '1;  // Write-only registers read as FF
        if (pal_hit) begin
            if (pal_off[0]) begin
                page_rd_data = {4'h0, sprite_pal[pal_idx][7:4]};
            end else begin
                page_rd_data = {sprite_pal[pal_idx][11:8], sprite_pal[pal_idx][3:0]};
            end
        end else if (dma_hit) begin
            page_rd_data = dcsr;  // Whole DMA block mirrors DCSR
        end
    end

endmodule

//--- rtl/cpu_read_mux.sv
module cpu_read_mux (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  logic                          io_rd_hit,
    input  logic [asic_pkg::data_w-1:0]   io_rd_data,
    input  logic                          page_rd_hit,
    input  logic [asic_pkg::data_w-1:0]   page_rd_data,
    output logic [asic_pkg::data_w-1:0]   cpu_data_out,
    output logic                          cpu_data_out_en
);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_data_out    <= '1;
            cpu_data_out_en <= 1'b0;
        end else if (page_rd_hit) begin
            // ASIC page wins if both ever respond
            cpu_data_out    <= page_rd_data;
            cpu_data_out_en <= 1'b1;
        end else if (io_rd_hit) begin
            cpu_data_out    <= io_rd_data;
            cpu_data_out_en <= 1'b1;
        end else begin
            cpu_data_out    <= '1;   // Idle bus floats high
            cpu_data_out_en <= 1'b0;
        end
    end

endmodule

//--- rtl/asic_regs_top.sv
module asic_regs_top (
    input  logic                            clk_sys,
    input  logic                            reset,
    input  asic_pkg::cpu_addr_t             cpu_addr,
    input  logic [asic_pkg::data_w-1:0]     cpu_data_in,
    input  logic                            cpu_wr,
    input  logic                            cpu_rd,
    output logic [asic_pkg::data_w-1:0]     cpu_data_out,
    output logic                            cpu_data_out_en,
    output logic [asic_pkg::data_w-1:0]     ram_config,
    output logic [asic_pkg::data_w-1:0]     rom_config,
    output logic [asic_pkg::data_w-1:0]     rom_select,
    output logic [asic_pkg::colour_w-1:0]   current_pen,
    output logic [asic_pkg::colour_w-1:0]   pen_ink,
    output logic [asic_pkg::data_w-1:0]     crtc_reg_select,
    output logic [asic_pkg::data_w-1:0]     crtc_regs [asic_pkg::crtc_reg_count],
    output logic                            acid_unlocked,
    output logic [asic_pkg::data_w-1:0]     raster_int_line,
    output logic [asic_pkg::data_w-1:0]     split_line,
    output logic [asic_pkg::data_w-1:0]     soft_scroll,
    output logic [asic_pkg::data_w-1:0]     dcsr
);

    logic                          io_rd_hit;
    logic [asic_pkg::data_w-1:0]   io_rd_data;
    logic                          page_rd_hit;
    logic [asic_pkg::data_w-1:0]   page_rd_data;

    // Gate array and CRTC ports
    io_port_regs u_io (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .cpu_addr        (cpu_addr),
        .cpu_data_in     (cpu_data_in),
        .cpu_wr          (cpu_wr),
        .cpu_rd          (cpu_rd),
        .io_rd_hit       (io_rd_hit),
        .io_rd_data      (io_rd_data),
        .ram_config      (ram_config),
        .rom_config      (rom_config),
        .rom_select      (rom_select),
        .current_pen     (current_pen),
        .pen_ink         (pen_ink),
        .crtc_reg_select (crtc_reg_select),
        .crtc_regs       (crtc_regs),
        .acid_unlocked   (acid_unlocked)
    );

    // Memory-mapped registers at 4000-7FFF
    plus_asic_page u_page (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .cpu_addr        (cpu_addr),
        .cpu_data_in     (cpu_data_in),
        .cpu_wr          (cpu_wr),
        .cpu_rd          (cpu_rd),
        .page_rd_hit     (page_rd_hit),
        .page_rd_data    (page_rd_data),
        .raster_int_line (raster_int_line),
        .split_line      (split_line),
        .soft_scroll     (soft_scroll),
        .dcsr            (dcsr)
    );

    cpu_read_mux u_rd_mux (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .io_rd_hit       (io_rd_hit),
        .io_rd_data      (io_rd_data),
        .page_rd_hit     (page_rd_hit),
        .page_rd_data    (page_rd_data),
        .cpu_data_out    (cpu_data_out),
        .cpu_data_out_en (cpu_data_out_en)
    );

endmodule

//--- verif/tb_asic_regs.sv
module tb_asic_regs;

    localparam int n_pen = 40;
    localparam int n_pal = 24;
    // Reset read, gate array, CRTC, unlock, palette, line and DMA operations
    localparam int n_ops = 1 + 3 * n_pen + 5 + 64 + 36 + 6 * n_pal + 28;
    localparam int watchdog_time = n_ops * 4 * 10 * 2;

    // Hardware colour number to {red, green, blue}
    localparam logic [11:0] colour_tab [0:31] = '{
        12'h666, 12'h666, 12'h0F6, 12'hFF6, 12'h006, 12'hF06, 12'h066, 12'hF66,
        12'hF06, 12'hFF6, 12'hFF0, 12'hFFF, 12'hF00, 12'hF0F, 12'hF60, 12'hF6F,
        12'h006, 12'h0F6, 12'h0F0, 12'h0FF, 12'h000, 12'h00F, 12'h060, 12'h06F,
        12'h606, 12'h6F6, 12'h6F0, 12'h6FF, 12'h600, 12'h60F, 12'h660, 12'h66F
    };
    localparam logic [7:0] acid_bytes [0:15] = '{
        8'hAA, 8'h00, 8'hFF, 8'h77, 8'hB3, 8'h51, 8'hA8, 8'hD4,
        8'h62, 8'h39, 8'h9C, 8'h46, 8'h2B, 8'h15, 8'h8A, 8'hCD
    };

    logic clk_sys = 1'b0;
    logic reset;
    asic_pkg::cpu_addr_t cpu_addr;
    logic [7:0] cpu_data_in;
    logic       cpu_wr;
    logic       cpu_rd;
    logic [7:0] cpu_data_out;
    logic       cpu_data_out_en;
    logic [7:0] ram_config;
    logic [7:0] rom_config;
    logic [7:0] rom_select;
    logic [4:0] current_pen;
    logic [4:0] pen_ink;
    logic [7:0] crtc_reg_select;
    logic [7:0] crtc_regs [asic_pkg::crtc_reg_count];
    logic       acid_unlocked;
    logic [7:0] raster_int_line;
    logic [7:0] split_line;
    logic [7:0] soft_scroll;
    logic [7:0] dcsr;

    // Shadow of the readable state
    logic [4:0]  m_ink [17];
    logic [4:0]  m_pen;
    logic [7:0]  m_mrer;
    logic [7:0]  m_ram;
    logic [7:0]  m_dcsr;
    logic [11:0] m_pal [32];

    logic [8:0] exp_q [$];   // {hit, data} per read
    logic [8:0] exp_rd;
    logic       rd_seen = 1'b0;
    int         seed = 36462;

    asic_regs_top dut0 (.*);

    always #5 clk_sys = ~clk_sys;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [asic_pkg::data_w-1:0] act,
                              input logic [asic_pkg::data_w-1:0] expected);
        if (act !== expected) begin
            abort_run($sformatf("error at %0t: %s = %h, expected %h", $time, name, act, expected));
        end
    endtask

    task automatic check_colour(input string name, input logic [asic_pkg::colour_w-1:0] act,
                                input logic [asic_pkg::colour_w-1:0] expected);
        if (act !== expected) begin
            abort_run($sformatf("error at %0t: %s = %h, expected %h", $time, name, act, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic expected) ;
        if (act !== expected) begin
            abort_run($sformatf("error at %0t: %s = %b, expected %b", $time, name, act, expected));
        end
    endtask

    task automatic model_write(input logic [15:0] a, input logic [7:0] d);
        if (a[15:8] == 8'h7F && a[7:0] <= 8'h10) begin
            if (d[7:6] == 2'b00) begin
                m_pen = d[4:0];
            end else if (m_pen < 17) begin
                m_ink[m_pen] = d[4:0];
            end
        end
        if (a == 16'h7F89) m_mrer = d;
        if (a >= 16'h7FC0 && a <= 16'h7FC7) m_ram = a[7:0];   // Value is the port low byte
        if (a >= 16'h6400 && a <= 16'h643F) begin
            if (a[0]) m_pal[a[5:1]][7:4] = d[3:0];
            else      m_pal[a[5:1]] = colour_tab[d[4:0]];
        end
        if (a == 16'h6C0F) m_dcsr = d;
    endtask

    // Expected {hit, data} for a read of address a
    function automatic logic [8:0] ref_read(input logic [15:0] a);
        logic [11:0] ent;
        ent = m_pal[a[5:1]];
        if (a >= 16'h6400 && a <= 16'h643F) return a[0] ? {5'b10000, ent[7:4]}
                                                        : {1'b1, ent[11:8], ent[3:0]};
        if (a >= 16'h6800 && a <= 16'h6807) return {1'b1, 8'hFF};
        if (a >= 16'h6C00 && a <= 16'h6C0F) return {1'b1, m_dcsr};
        if (a == 16'h7F10) return {4'b1000, m_ink[m_pen]};
        if (a == 16'h7F89) return {1'b1, m_mrer};
        if (a == 16'h7FC0) return {1'b1, m_ram};
        return {1'b0, 8'hFF};   // Nothing responds
    endfunction

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk_sys);
        cpu_addr    = a;
        cpu_data_in = d;
        cpu_wr      = 1'b1;
        model_write(a, d);
        @(negedge clk_sys);
        cpu_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a);
        @(negedge clk_sys);
        cpu_addr = a;
        cpu_rd   = 1'b1;
        exp_q.push_back(ref_read(a));
        @(negedge clk_sys);
        cpu_rd = 1'b0;
    endtask

    always @(posedge clk_sys) rd_seen <= cpu_rd;

    // Read results land one cycle after the strobe
    always @(negedge clk_sys) begin
        if (rd_seen && exp_q.size() == 0) begin
            abort_run("read strobe seen with no expected result queued");
        end else if (rd_seen) begin
            exp_rd = exp_q.pop_front();
            if (exp_rd[8] && !cpu_data_out_en) begin
                abort_run($sformatf("no cpu_data_out_en pulse after read at %0t", $time));
            end else if (!exp_rd[8] && cpu_data_out_en) begin
                abort_run("cpu_data_out_en pulsed for an unmapped read");
            end
            check_byte("cpu_data_out", cpu_data_out, exp_rd[7:0]);
        end else if (cpu_data_out_en) begin
            abort_run("cpu_data_out_en pulsed without a read");
        end
    end

    initial begin
        #(watchdog_time);
        abort_run("watchdog timeout, the test did not finish in time");
    end

    initial begin
        logic [31:0] r;
        logic [4:0]  pen;
        logic [15:0] a;
        reset       = 1'b1;
        cpu_addr    = '0;
        cpu_data_in = '0;
        cpu_wr      = 1'b0;
        cpu_rd      = 1'b0;
        m_pen  = '0;
        m_mrer = '0;
        m_ram  = '0;
        m_dcsr = '0;
        for (int i = 0; i < 17; i++) m_ink[i] = '0;
        for (int i = 0; i < 32; i++) m_pal[i] = '0;
        repeat (4) @(negedge clk_sys);
        reset = 1'b0;

        check_byte("ram_config", ram_config, 8'h00);
        check_byte("rom_config", rom_config, 8'h00);
        check_byte("rom_select", rom_select, 8'h00);
        check_colour("current_pen", current_pen, 5'd0);
        check_colour("pen_ink", pen_ink, 5'd0);
        check_byte("crtc_reg_select", crtc_reg_select, 8'h00);
        check_bit("acid_unlocked", acid_unlocked, 1'b0);
        check_byte("raster_int_line", raster_int_line, 8'h00);
        check_byte("split_line", split_line, 8'h00);
        check_byte("soft_scroll", soft_scroll, 8'h00);
        check_byte("dcsr", dcsr, 8'h00);
        for (int i = 0; i < 32; i++) begin
            check_byte($sformatf("crtc_regs[%0d]", i), crtc_regs[i], 8'h00);
        end
        bus_read(16'h1234);

        // Pen select then ink write, both on random gate array ports
        for (int i = 0; i < n_pen; i++) begin
            r   = $random(seed);
            pen = 5'(r[7:0] % 17);
            bus_write({8'h7F, 8'(r[15:8] % 17)}, {3'b000, pen});
            check_colour("current_pen", current_pen, pen);
            check_colour("pen_ink", pen_ink, m_ink[pen]);
            bus_write({8'h7F, 8'(r[31:24] % 17)}, {1'b1, r[22:16]});
            check_colour("pen_ink", pen_ink, r[20:16]);
            bus_read(16'h7F10);
        end
        r = $random(seed);
        bus_write(16'h7F89, r[7:0]);
        check_byte("rom_config", rom_config, r[7:0]);
        bus_read(16'h7F89);
        bus_write({8'h7F, 5'b11000, r[10:8]}, r[15:8]);
        check_byte("ram_config", ram_config, {5'b11000, r[10:8]});
        bus_read(16'h7FC0);
        bus_write(16'hDF00, r[23:16]);
        check_byte("rom_select", rom_select, r[23:16]);

        // Locked, so only 0-15 take the data
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            bus_write(16'hBC00, 8'(i));
            bus_write(16'hBD00, r[7:0]);
            check_byte("crtc_reg_select", crtc_reg_select, 8'(i));
            check_byte($sformatf("crtc_regs[%0d]", i), crtc_regs[i], (i < 16) ? r[7:0] : 8'h00);
        end

        for (int i = 0; i < 4; i++) bus_write(16'hBC00, acid_bytes[i]);
        bus_write(16'hBC00, 8'h12);   // Breaks the sequence
        for (int i = 4; i < 16; i++) bus_write(16'hBC00, acid_bytes[i]);
        check_bit("acid_unlocked", acid_unlocked, 1'b0);
        for (int i = 0; i < 16; i++) begin
            bus_write(16'hBC00, acid_bytes[i]);
            if (i == 5) bus_write(16'hBC00, acid_bytes[i]);   // Repeat is skipped
            check_bit("acid_unlocked", acid_unlocked, i == 15);
        end
        bus_write(16'hBC00, 8'd20);
        bus_write(16'hBD00, 8'h5A);
        check_byte("crtc_regs[20]", crtc_regs[20], 8'h5A);

        for (int i = 0; i < n_pal; i++) begin
            r = $random(seed);
            a = 16'h6400 + {10'd0, r[4:0], 1'b0};
            bus_write(a, r[15:8]);
            bus_read(a);
            bus_read(a | 16'h0001);
            if (r[16]) begin
                bus_write(a | 16'h0001, r[27:20]);   // Green override
                bus_read(a | 16'h0001);
                bus_read(a);
            end
        end

        r = $random(seed);
        bus_write(16'h6800, r[7:0]);
        check_byte("raster_int_line", raster_int_line, r[7:0]);
        bus_write(16'h6801, r[15:8]);
        check_byte("split_line", split_line, r[15:8]);
        bus_write(16'h6804, r[23:16]);
        check_byte("soft_scroll", soft_scroll, r[23:16]);
        for (int i = 0; i < 8; i++) bus_read(16'h6800 + 16'(i));
        bus_write(16'h6C0F, r[31:24]);
        check_byte("dcsr", dcsr, r[31:24]);
        for (int i = 0; i < 16; i++) bus_read(16'h6C00 + 16'(i));

        repeat (2) @(negedge clk_sys);
        if (exp_q.size() != 0) begin
            abort_run("some read results were never checked");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- vlog.f
rtl/asic_pkg.sv
rtl/acid_unlock.sv
rtl/io_port_regs.sv
rtl/plus_asic_page.sv
rtl/cpu_read_mux.sv
rtl/asic_regs_top.sv
verif/tb_asic_regs.sv

//--- Makefile
TOP = tb_asic_regs

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
